/* tg_pkg.sv */
`default_nettype none

package tg_pkg;

	// Sequencer FSM
	typedef enum logic [2:0]
	{
		TG_IDLE,	// Out of reset, waits for start
		TG_WRITE,	// Write command offered
		TG_WAIT_WR,	// Bridge busy with the write
		TG_READ,	// Read command offered
		TG_WAIT_RD,	// Waiting for the folded read word
		TG_DONE		// Run finished, results held
	} tg_state_e;

	// App command field, same code points as the MIG app_cmd
	typedef enum logic [2:0]
	{
		CMD_WRITE = 3'd0,
		CMD_READ  = 3'd1
	} app_cmd_e;

	localparam int ERR_CNT_WIDTH = 16;	// Saturating mismatch counter

endpackage

`default_nettype wire

/* axi_pkg.sv */
`default_nettype none

package axi_pkg;

	// AXI beat carries this many app words
	localparam int LANE_FACTOR = 4;

	localparam logic [1:0] AXI_BURST_INCR = 2'b01;
	localparam logic [1:0] AXI_RESP_OKAY = 2'b00;
	localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;	// Slave error code
	localparam logic [7:0] AXI_LEN_SINGLE = 8'd0;	// One beat, len is beats minus one

	// Bridge FSM, one command in flight
	typedef enum logic [2:0]
	{
		BR_IDLE,		// app rdy high
		BR_WR_ADDR_DATA,	// AW and W raised together
		BR_WR_RESP,		// Waiting on B
		BR_RD_ADDR,		// AR raised
		BR_RD_DATA,		// Waiting on R
		BR_RD_FOLD		// Beat in the fold pipeline
	} bridge_state_e;

endpackage

`default_nettype wire

/* app_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface app_if #(
	parameter int DATA_WIDTH = 32,
	parameter int ADDR_WIDTH = 16
) ();
	import tg_pkg::*;

	// Command side, from the sequencer
	logic			en;		// Held until rdy
	app_cmd_e		cmd;
	logic [ADDR_WIDTH-1:0]	addr;		// Word address
	logic [DATA_WIDTH-1:0]	wdata;		// Travels with a write command

	// Return side, from the bridge
	logic			rdy;		// Bridge idle
	logic			rd_valid;	// One cycle pulse
	logic [DATA_WIDTH-1:0]	rd_data;
	logic			rd_err;		// Lane mismatch or bad response

	modport master (output en, cmd, addr, wdata, input rdy, rd_valid, rd_data, rd_err);
	modport slave (input en, cmd, addr, wdata, output rdy, rd_valid, rd_data, rd_err);

endinterface

`default_nettype wire

/* tg_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module tg_sequencer #(
	parameter int APP_DATA_WIDTH = 32,
	parameter int APP_ADDR_WIDTH = 16,
	parameter int NUM_WORDS = 16
) (
	input wire				i_clk,
	input wire				i_rst,
	input wire				i_calib_done,
	input wire				i_start,
	input wire [APP_ADDR_WIDTH-1:0]		i_start_addr,
	app_if.master				app,
	output logic				o_busy,
	output logic				o_done,
	output logic [tg_pkg::ERR_CNT_WIDTH-1:0]	o_err_cnt,
	output logic				o_first_err_valid,
	output logic [APP_ADDR_WIDTH-1:0]	o_first_err_addr
);
	import tg_pkg::*;

	localparam int HALF = APP_DATA_WIDTH / 2;
	localparam int CNT_W = $clog2(NUM_WORDS) + 1;	// Room for NUM_WORDS-1 at any size

	tg_state_e			state;
	logic [CNT_W-1:0]		idx;		// Word index within the block
	logic [APP_ADDR_WIDTH-1:0]	base_addr;	// Start address, latched at start
	logic [APP_ADDR_WIDTH-1:0]	word_addr;
	logic [APP_DATA_WIDTH-1:0]	exp_data;
	logic				last_word;
	logic				start_ok;
	logic				rd_bad;

	// Pattern, inverted address on top, address below
	function automatic logic [APP_DATA_WIDTH-1:0] pattern(input logic [APP_ADDR_WIDTH-1:0] a);
		logic [APP_ADDR_WIDTH-1:0]	inv;
		logic [HALF-1:0]		hi;
		logic [HALF-1:0]		lo;
		inv = ~a;			// Invert before widening
		hi = HALF'(inv);
		lo = HALF'(a);
		return {hi, lo};
	endfunction

	assign word_addr = base_addr + APP_ADDR_WIDTH'(idx);
	assign exp_data = pattern(word_addr);
	assign last_word = (idx == CNT_W'(NUM_WORDS - 1));
	assign start_ok = i_start && i_calib_done && (state == TG_IDLE || state == TG_DONE);
	assign rd_bad = app.rd_err || (app.rd_data != exp_data);

	// Command fields straight from registers, stable until rdy
	assign app.en = (state == TG_WRITE) || (state == TG_READ);
	assign app.cmd = (state == TG_READ) ? CMD_READ : CMD_WRITE;
	assign app.addr = word_addr;
	assign app.wdata = exp_data;	// Ignored by the bridge on reads

	assign o_busy = (state != TG_IDLE) && (state != TG_DONE);
	assign o_done = (state == TG_DONE);	// Held until the next start

	always_ff @(posedge i_clk)
	begin
		if (start_ok)
			base_addr <= i_start_addr;
	end

	always_ff @(posedge i_clk or posedge i_rst)
	begin
		if (i_rst)
		begin
			state <= TG_IDLE;
			idx <= '0;
			o_err_cnt <= '0;
			o_first_err_valid <= 1'b0;
			o_first_err_addr <= '0;
		end
		else
		begin
			case (state)
				TG_IDLE, TG_DONE:
				begin
					if (start_ok)
					begin
						state <= TG_WRITE;
						idx <= '0;
						o_err_cnt <= '0;		// Fresh results per run
						o_first_err_valid <= 1'b0;
					end
				end
				TG_WRITE:
				begin
					if (app.rdy)
						state <= TG_WAIT_WR;	// Accepted this cycle
				end
				TG_WAIT_WR:
				begin
					// rdy back means B has been taken
					if (app.rdy)
					begin
						if (last_word)
						begin
							state <= TG_READ;
							idx <= '0;
						end
						else
						begin
							state <= TG_WRITE;
							idx <= idx + 1'b1;
						end
					end
				end
				TG_READ:
				begin
					if (app.rdy)
						state <= TG_WAIT_RD;
				end
				TG_WAIT_RD:
				begin
					if (app.rd_valid)
					begin
						if (rd_bad)
						begin
							if (o_err_cnt != '1)	// Saturate
								o_err_cnt <= o_err_cnt + 1'b1;
							if (!o_first_err_valid)
							begin
								o_first_err_valid <= 1'b1;
								o_first_err_addr <= word_addr;
							end
						end
						if (last_word)
							state <= TG_DONE;
						else
						begin
							state <= TG_READ;
							idx <= idx + 1'b1;
						end
					end
				end
				default:
					state <= TG_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* app_axi_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module app_axi_bridge #(
	parameter int APP_DATA_WIDTH = 32,
	parameter int APP_ADDR_WIDTH = 16,
	parameter int AXI_ID_WIDTH = 4,
	localparam int AXI_DATA_WIDTH = APP_DATA_WIDTH * axi_pkg::LANE_FACTOR,
	localparam int AXI_SIZE = $clog2(AXI_DATA_WIDTH / 8),
	localparam int AXI_ADDR_WIDTH = APP_ADDR_WIDTH + AXI_SIZE
) (
	input wire				i_clk,
	input wire				i_rst,
	app_if.slave				app,
	// Write address
	output logic [AXI_ID_WIDTH-1:0]		o_m_axi_awid,
	output logic [AXI_ADDR_WIDTH-1:0]	o_m_axi_awaddr,
	output logic [7:0]			o_m_axi_awlen,
	output logic [2:0]			o_m_axi_awsize,
	output logic [1:0]			o_m_axi_awburst,
	output logic				o_m_axi_awvalid,
	input wire				i_m_axi_awready,
	// Write data and response
	output logic [AXI_DATA_WIDTH-1:0]	o_m_axi_wdata,
	output logic [AXI_DATA_WIDTH/8-1:0]	o_m_axi_wstrb,
	output logic				o_m_axi_wlast,
	output logic				o_m_axi_wvalid,
	input wire				i_m_axi_wready,
	input wire [1:0]			i_m_axi_bresp,
	input wire				i_m_axi_bvalid,
	output logic				o_m_axi_bready,
	// Read address and data
	output logic [AXI_ID_WIDTH-1:0]		o_m_axi_arid,
	output logic [AXI_ADDR_WIDTH-1:0]	o_m_axi_araddr,
	output logic [7:0]			o_m_axi_arlen,
	output logic [2:0]			o_m_axi_arsize,
	output logic [1:0]			o_m_axi_arburst,
	output logic				o_m_axi_arvalid,
	input wire				i_m_axi_arready,
	input wire [AXI_DATA_WIDTH-1:0]		i_m_axi_rdata,
	input wire [1:0]			i_m_axi_rresp,
	input wire				i_m_axi_rvalid,
	output logic				o_m_axi_rready,
	// Fold pipeline link
	output logic				o_beat_valid,
	output logic [AXI_DATA_WIDTH-1:0]	o_beat_data,
	output logic [1:0]			o_beat_resp,
	input wire				i_fold_valid,
	input wire [APP_DATA_WIDTH-1:0]		i_fold_data,
	input wire				i_fold_err
);
	import axi_pkg::*;
	import tg_pkg::*;

	localparam int HALF = APP_DATA_WIDTH / 2;

	bridge_state_e			state;
	logic [AXI_ADDR_WIDTH-1:0]	addr_q;		// Byte address of the command
	logic [APP_DATA_WIDTH-1:0]	wdata_q;
	logic				awvalid_q;
	logic				wvalid_q;
	logic				wr_err;		// Bad bresp, reported on the next read

	assign app.rdy = (state == BR_IDLE);

	// Same ID, size and single beat on every transaction
	assign o_m_axi_awid = '0;
	assign o_m_axi_awaddr = addr_q;
	assign o_m_axi_awlen = AXI_LEN_SINGLE;
	assign o_m_axi_awsize = 3'(AXI_SIZE);
	assign o_m_axi_awburst = AXI_BURST_INCR;
	assign o_m_axi_awvalid = awvalid_q;
	assign o_m_axi_arid = '0;
	assign o_m_axi_araddr = addr_q;
	assign o_m_axi_arlen = AXI_LEN_SINGLE;
	assign o_m_axi_arsize = 3'(AXI_SIZE);
	assign o_m_axi_arburst = AXI_BURST_INCR;

	// Each half doubled, doubled word repeated, so lanes read hi hi lo lo from the top
	assign o_m_axi_wdata = {(LANE_FACTOR / 2){{2{wdata_q[HALF +: HALF]}}, {2{wdata_q[0 +: HALF]}}}};
	assign o_m_axi_wstrb = '1;		// Full beat every time
	assign o_m_axi_wlast = 1'b1;
	assign o_m_axi_wvalid = wvalid_q;

	assign o_m_axi_bready = (state == BR_WR_RESP);
	assign o_m_axi_rready = (state == BR_RD_DATA);

	// Raw beat into the fold pipeline on the R handshake
	assign o_beat_valid = i_m_axi_rvalid && (state == BR_RD_DATA);
	assign o_beat_data = i_m_axi_rdata;
	assign o_beat_resp = i_m_axi_rresp;

	assign app.rd_valid = i_fold_valid && (state == BR_RD_FOLD);
	assign app.rd_data = i_fold_data;
	assign app.rd_err = i_fold_err || wr_err;

	// Word to byte address shift
	always_ff @(posedge i_clk)
	begin
		if (app.en && state == BR_IDLE)
		begin
			addr_q <= {app.addr, {AXI_SIZE{1'b0}}};
			wdata_q <= app.wdata;
		end
	end

	always_ff @(posedge i_clk or posedge i_rst)
	begin
		if (i_rst)
		begin
			state <= BR_IDLE;
			awvalid_q <= 1'b0;
			wvalid_q <= 1'b0;
			o_m_axi_arvalid <= 1'b0;
			wr_err <= 1'b0;
		end
		else
		begin
			case (state)
				BR_IDLE:
				begin
					if (app.en && app.cmd == CMD_WRITE)
					begin
						state <= BR_WR_ADDR_DATA;
						awvalid_q <= 1'b1;
						wvalid_q <= 1'b1;
					end
					else if (app.en)
					begin
						state <= BR_RD_ADDR;
						o_m_axi_arvalid <= 1'b1;
					end
				end
				BR_WR_ADDR_DATA:
				begin
					if (i_m_axi_awready)
						awvalid_q <= 1'b0;
					if (i_m_axi_wready)
						wvalid_q <= 1'b0;
					// AW and W may finish in either order
					if ((!awvalid_q || i_m_axi_awready) && (!wvalid_q || i_m_axi_wready))
						state <= BR_WR_RESP;
				end
				BR_WR_RESP:
				begin
					if (i_m_axi_bvalid)
					begin
						state <= BR_IDLE;
						if (i_m_axi_bresp != AXI_RESP_OKAY)
							wr_err <= 1'b1;
					end
				end
				BR_RD_ADDR:
				begin
					if (i_m_axi_arready)
					begin
						state <= BR_RD_DATA;
						o_m_axi_arvalid <= 1'b0;
					end
				end
				BR_RD_DATA:
				begin
					if (i_m_axi_rvalid)
						state <= BR_RD_FOLD;
				end
				BR_RD_FOLD:
				begin
					if (i_fold_valid)
					begin
						state <= BR_IDLE;
						wr_err <= 1'b0;	// Reported with this read
					end
				end
				default:
					state <= BR_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* lane_fold.sv */
`timescale 1ns/1ps
`default_nettype none

module lane_fold #(
	parameter int APP_DATA_WIDTH = 32,
	localparam int AXI_DATA_WIDTH = APP_DATA_WIDTH * axi_pkg::LANE_FACTOR
) (
	input wire				i_clk,
	input wire				i_rst,
	input wire				i_beat_valid,
	input wire [AXI_DATA_WIDTH-1:0]		i_beat_data,
	input wire [1:0]			i_beat_resp,
	output logic				o_valid,
	output logic [APP_DATA_WIDTH-1:0]	o_data,
	output logic				o_err
);
	import axi_pkg::*;

	localparam int HALF = APP_DATA_WIDTH / 2;
	localparam int NUM_CHUNKS = 2 * LANE_FACTOR;	// Half-word slices per beat

	logic				s1_valid;
	logic [AXI_DATA_WIDTH-1:0]	s1_beat;
	logic [1:0]			s1_resp;
	logic				lane_mis;

	// Slices 0,1,4,5 hold the low half, 2,3,6,7 the high half
	always_comb
	begin
		lane_mis = 1'b0;
		for (int k = 0; k < NUM_CHUNKS; k++)
		begin
			if ((k % 4) < 2)
				lane_mis |= (s1_beat[k*HALF +: HALF] != s1_beat[0 +: HALF]);
			else
				lane_mis |= (s1_beat[k*HALF +: HALF] != s1_beat[2*HALF +: HALF]);
		end
	end

	// Stage 1 beat, stage 2 word, a new beat may enter every cycle
	always_ff @(posedge i_clk)
	begin
		s1_beat <= i_beat_data;
		s1_resp <= i_beat_resp;
		o_data <= {s1_beat[2*HALF +: HALF], s1_beat[0 +: HALF]};	// Lowest copies
		o_err <= lane_mis || (s1_resp != AXI_RESP_OKAY);
	end

	always_ff @(posedge i_clk or posedge i_rst)
	begin
		if (i_rst)
		begin
			s1_valid <= 1'b0;
			o_valid <= 1'b0;
		end
		else
		begin
			s1_valid <= i_beat_valid;
			o_valid <= s1_valid;
		end
	end

endmodule

`default_nettype wire

/* traffic_top.sv */
`timescale 1ns/1ps
`default_nettype none

module traffic_top #(
	parameter int APP_DATA_WIDTH = 32,	// Must be even
	parameter int APP_ADDR_WIDTH = 16,
	parameter int AXI_ID_WIDTH = 4,
	parameter int NUM_WORDS = 16,
	localparam int AXI_DATA_WIDTH = APP_DATA_WIDTH * axi_pkg::LANE_FACTOR,
	localparam int AXI_ADDR_WIDTH = APP_ADDR_WIDTH + $clog2(AXI_DATA_WIDTH / 8)
) (
	input wire				i_clk,
	input wire				i_rst,
	input wire				i_calib_done,
	input wire				i_start,
	input wire [APP_ADDR_WIDTH-1:0]		i_start_addr,
	// Status
	output wire				o_busy,
	output wire				o_done,
	output wire [tg_pkg::ERR_CNT_WIDTH-1:0]	o_err_cnt,
	output wire				o_first_err_valid,
	output wire [APP_ADDR_WIDTH-1:0]	o_first_err_addr,
	// AXI master
	output wire [AXI_ID_WIDTH-1:0]		o_m_axi_awid,
	output wire [AXI_ADDR_WIDTH-1:0]	o_m_axi_awaddr,
	output wire [7:0]			o_m_axi_awlen,
	output wire [2:0]			o_m_axi_awsize,
	output wire [1:0]			o_m_axi_awburst,
	output wire				o_m_axi_awvalid,
	input wire				i_m_axi_awready,
	output wire [AXI_DATA_WIDTH-1:0]	o_m_axi_wdata,
	output wire [AXI_DATA_WIDTH/8-1:0]	o_m_axi_wstrb,
	output wire				o_m_axi_wlast,
	output wire				o_m_axi_wvalid,
	input wire				i_m_axi_wready,
	input wire [1:0]			i_m_axi_bresp,
	input wire				i_m_axi_bvalid,
	output wire				o_m_axi_bready,
	output wire [AXI_ID_WIDTH-1:0]		o_m_axi_arid,
	output wire [AXI_ADDR_WIDTH-1:0]	o_m_axi_araddr,
	output wire [7:0]			o_m_axi_arlen,
	output wire [2:0]			o_m_axi_arsize,
	output wire [1:0]			o_m_axi_arburst,
	output wire				o_m_axi_arvalid,
	input wire				i_m_axi_arready,
	input wire [AXI_DATA_WIDTH-1:0]		i_m_axi_rdata,
	input wire [1:0]			i_m_axi_rresp,
	input wire				i_m_axi_rvalid,
	output wire				o_m_axi_rready
);

	// Bridge to fold pipeline
	logic				beat_valid;
	logic [AXI_DATA_WIDTH-1:0]	beat_data;
	logic [1:0]			beat_resp;
	logic				fold_valid;
	logic [APP_DATA_WIDTH-1:0]	fold_data;
	logic				fold_err;

	app_if #(
		.DATA_WIDTH	(APP_DATA_WIDTH),
		.ADDR_WIDTH	(APP_ADDR_WIDTH)
	) u_app_if ();

	tg_sequencer #(
		.APP_DATA_WIDTH	(APP_DATA_WIDTH),
		.APP_ADDR_WIDTH	(APP_ADDR_WIDTH),
		.NUM_WORDS	(NUM_WORDS)
	) u_tg_sequencer (
		.i_clk			(i_clk),
		.i_rst			(i_rst),
		.i_calib_done		(i_calib_done),
		.i_start		(i_start),
		.i_start_addr		(i_start_addr),
		.app			(u_app_if.master),
		.o_busy			(o_busy),
		.o_done			(o_done),
		.o_err_cnt		(o_err_cnt),
		.o_first_err_valid	(o_first_err_valid),
		.o_first_err_addr	(o_first_err_addr)
	);

	app_axi_bridge #(
		.APP_DATA_WIDTH	(APP_DATA_WIDTH),
		.APP_ADDR_WIDTH	(APP_ADDR_WIDTH),
		.AXI_ID_WIDTH	(AXI_ID_WIDTH)
	) u_app_axi_bridge (
		.i_clk			(i_clk),
		.i_rst			(i_rst),
		.app			(u_app_if.slave),
		.o_m_axi_awid		(o_m_axi_awid),
		.o_m_axi_awaddr		(o_m_axi_awaddr),
		.o_m_axi_awlen		(o_m_axi_awlen),
		.o_m_axi_awsize		(o_m_axi_awsize),
		.o_m_axi_awburst	(o_m_axi_awburst),
		.o_m_axi_awvalid	(o_m_axi_awvalid),
		.i_m_axi_awready	(i_m_axi_awready),
		.o_m_axi_wdata		(o_m_axi_wdata),
		.o_m_axi_wstrb		(o_m_axi_wstrb),
		.o_m_axi_wlast		(o_m_axi_wlast),
		.o_m_axi_wvalid		(o_m_axi_wvalid),
		.i_m_axi_wready		(i_m_axi_wready),
		.i_m_axi_bresp		(i_m_axi_bresp),
		.i_m_axi_bvalid		(i_m_axi_bvalid),
		.o_m_axi_bready		(o_m_axi_bready),
		.o_m_axi_arid		(o_m_axi_arid),
		.o_m_axi_araddr		(o_m_axi_araddr),
		.o_m_axi_arlen		(o_m_axi_arlen),
		.o_m_axi_arsize		(o_m_axi_arsize),
		.o_m_axi_arburst	(o_m_axi_arburst),
		.o_m_axi_arvalid	(o_m_axi_arvalid),
		.i_m_axi_arready	(i_m_axi_arready),
		.i_m_axi_rdata		(i_m_axi_rdata),
		.i_m_axi_rresp		(i_m_axi_rresp),
		.i_m_axi_rvalid		(i_m_axi_rvalid),
		.o_m_axi_rready		(o_m_axi_rready),
		.o_beat_valid		(beat_valid),
		.o_beat_data		(beat_data),
		.o_beat_resp		(beat_resp),
		.i_fold_valid		(fold_valid),
		.i_fold_data		(fold_data),
		.i_fold_err		(fold_err)
	);

	lane_fold #(
		.APP_DATA_WIDTH	(APP_DATA_WIDTH)
	) u_lane_fold (
		.i_clk		(i_clk),
		.i_rst		(i_rst),
		.i_beat_valid	(beat_valid),
		.i_beat_data	(beat_data),
		.i_beat_resp	(beat_resp),
		.o_valid	(fold_valid),
		.o_data		(fold_data),
		.o_err		(fold_err)
	);

endmodule

`default_nettype wire

/* tb_axi_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_axi_mem #(
	parameter int ADDR_WIDTH = 20,
	parameter int DATA_WIDTH = 128,
	parameter int SEED = 32'h31654fcd
) (
	input wire			i_clk,
	input wire			i_rst,
	input wire [ADDR_WIDTH-1:0]	i_awaddr,
	input wire			i_awvalid,
	output logic			o_awready,
	input wire [DATA_WIDTH-1:0]	i_wdata,
	input wire			i_wvalid,
	output logic			o_wready,
	output logic [1:0]		o_bresp,
	output logic			o_bvalid,
	input wire			i_bready,
	input wire [ADDR_WIDTH-1:0]	i_araddr,
	input wire			i_arvalid,
	output logic			o_arready,
	output logic [DATA_WIDTH-1:0]	o_rdata,
	output logic [1:0]		o_rresp,
	output logic			o_rvalid,
	input wire			i_rready,
	// Fault hooks, byte addresses
	input wire			i_corrupt_en,
	input wire [ADDR_WIDTH-1:0]	i_corrupt_addr,
	input wire			i_bad_resp_en,
	input wire [ADDR_WIDTH-1:0]	i_bad_resp_addr
);
	import axi_pkg::*;

	localparam int SLICE = DATA_WIDTH / (2 * LANE_FACTOR);	// One half-word copy
	localparam int BAD_SLICE = 6;				// A high-half copy, not the lowest

	logic [DATA_WIDTH-1:0]	mem [logic [ADDR_WIDTH-1:0]];	// Sparse, by byte address
	integer			seed = SEED;
	int			aw_dly;
	int			w_dly;
	int			ar_dly;
	int			r_dly;
	logic			aw_got;		// AW taken, waiting for W
	logic			w_got;
	logic			rd_pend;	// AR taken, R not yet done
	logic [ADDR_WIDTH-1:0]	aw_addr;
	logic [ADDR_WIDTH-1:0]	rd_addr;
	logic [DATA_WIDTH-1:0]	w_data;

	// Ready or valid delay of 0 to 3 cycles
	function automatic int pick_delay();
		return int'($unsigned($random(seed)) % 4);
	endfunction

	always @(posedge i_clk or posedge i_rst)
	begin
		logic [DATA_WIDTH-1:0] beat;
		if (i_rst)
		begin
			o_awready <= 1'b0;
			o_wready <= 1'b0;
			o_arready <= 1'b0;
			o_bvalid <= 1'b0;
			o_rvalid <= 1'b0;
			o_bresp <= AXI_RESP_OKAY;
			o_rresp <= AXI_RESP_OKAY;
			o_rdata <= '0;
			aw_got <= 1'b0;
			w_got <= 1'b0;
			rd_pend <= 1'b0;
			aw_dly <= 0;
			w_dly <= 0;
			ar_dly <= 0;
			r_dly <= 0;
		end
		else
		begin
			if (o_awready && i_awvalid)
			begin
				o_awready <= 1'b0;
				aw_got <= 1'b1;
				aw_addr <= i_awaddr;
				aw_dly <= pick_delay();
			end
			else if (i_awvalid && !aw_got && !o_awready)
			begin
				if (aw_dly == 0)
					o_awready <= 1'b1;
				else
					aw_dly <= aw_dly - 1;
			end
			if (o_wready && i_wvalid)
			begin
				o_wready <= 1'b0;
				w_got <= 1'b1;
				w_data <= i_wdata;
				w_dly <= pick_delay();
			end
			else if (i_wvalid && !w_got && !o_wready)
			begin
				if (w_dly == 0)
					o_wready <= 1'b1;
				else
					w_dly <= w_dly - 1;
			end
			// Store once both halves of the write are in
			if (aw_got && w_got && !o_bvalid)
			begin
				beat = w_data;
				if (i_corrupt_en && aw_addr == i_corrupt_addr)
					beat[BAD_SLICE*SLICE +: SLICE] = ~beat[BAD_SLICE*SLICE +: SLICE];
				mem[aw_addr] = beat;
				aw_got <= 1'b0;
				w_got <= 1'b0;
				o_bvalid <= 1'b1;
				o_bresp <= AXI_RESP_OKAY;
			end
			else if (o_bvalid && i_bready)
				o_bvalid <= 1'b0;
			if (o_arready && i_arvalid)
			begin
				o_arready <= 1'b0;
				rd_pend <= 1'b1;
				rd_addr <= i_araddr;
				ar_dly <= pick_delay();
				r_dly <= pick_delay();
			end
			else if (i_arvalid && !rd_pend && !o_arready)
			begin
				if (ar_dly == 0)
					o_arready <= 1'b1;
				else
					ar_dly <= ar_dly - 1;
			end
			if (o_rvalid && i_rready)
			begin
				o_rvalid <= 1'b0;
				rd_pend <= 1'b0;
			end
			else if (rd_pend && !o_rvalid)
			begin
				if (r_dly == 0)
				begin
					o_rvalid <= 1'b1;
					o_rdata <= mem.exists(rd_addr) ? mem[rd_addr] : '0;	// Unwritten reads zero
					o_rresp <= (i_bad_resp_en && rd_addr == i_bad_resp_addr) ?
						AXI_RESP_SLVERR : AXI_RESP_OKAY;
				end
				else
					r_dly <= r_dly - 1;
			end
		end
	end

endmodule

`default_nettype wire

/* tb_traffic_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_traffic_top;
	import tg_pkg::*;
	import axi_pkg::*;

	localparam int APP_DATA_WIDTH = 32;
	localparam int APP_ADDR_WIDTH = 16;
	localparam int AXI_ID_WIDTH = 4;
	localparam int NUM_WORDS = 16;
	localparam int HALF = APP_DATA_WIDTH / 2;
	localparam int AXI_DATA_WIDTH = APP_DATA_WIDTH * LANE_FACTOR;
	localparam int AXI_BYTES = AXI_DATA_WIDTH / 8;
	localparam int AXI_ADDR_WIDTH = APP_ADDR_WIDTH + $clog2(AXI_BYTES);
	localparam int TIMEOUT = 5000;	// Cycles per wait

	localparam logic [APP_ADDR_WIDTH-1:0] BASE_A = 16'h0100;
	localparam logic [APP_ADDR_WIDTH-1:0] BASE_B = 16'h0200;
	localparam logic [APP_ADDR_WIDTH-1:0] CORRUPT_WORD = 16'h0105;
	localparam logic [APP_ADDR_WIDTH-1:0] BAD_RESP_WORD = 16'h020b;

	logic				clk;
	logic				rst;
	logic				calib_done;
	logic				start;
	logic [APP_ADDR_WIDTH-1:0]	start_addr;
	logic				busy;
	logic				done;
	logic [ERR_CNT_WIDTH-1:0]	err_cnt;
	logic				first_err_valid;
	logic [APP_ADDR_WIDTH-1:0]	first_err_addr;
	logic [AXI_ID_WIDTH-1:0]	m_axi_awid;
	logic [AXI_ADDR_WIDTH-1:0]	m_axi_awaddr;
	logic [7:0]			m_axi_awlen;
	logic [2:0]			m_axi_awsize;
	logic [1:0]			m_axi_awburst;
	logic				m_axi_awvalid;
	logic				m_axi_awready;
	logic [AXI_DATA_WIDTH-1:0]	m_axi_wdata;
	logic [AXI_BYTES-1:0]		m_axi_wstrb;
	logic				m_axi_wlast;
	logic				m_axi_wvalid;
	logic				m_axi_wready;
	logic [1:0]			m_axi_bresp;
	logic				m_axi_bvalid;
	logic				m_axi_bready;
	logic [AXI_ID_WIDTH-1:0]	m_axi_arid;
	logic [AXI_ADDR_WIDTH-1:0]	m_axi_araddr;
	logic [7:0]			m_axi_arlen;
	logic [2:0]			m_axi_arsize;
	logic [1:0]			m_axi_arburst;
	logic				m_axi_arvalid;
	logic				m_axi_arready;
	logic [AXI_DATA_WIDTH-1:0]	m_axi_rdata;
	logic [1:0]			m_axi_rresp;
	logic				m_axi_rvalid;
	logic				m_axi_rready;
	logic				corrupt_en;
	logic [AXI_ADDR_WIDTH-1:0]	corrupt_addr;
	logic				bad_resp_en;
	logic [AXI_ADDR_WIDTH-1:0]	bad_resp_addr;

	logic [APP_ADDR_WIDTH-1:0]	run_base;	// Start address of the current run
	int				aw_idx;		// AW handshakes in this run
	int				ar_idx;
	int				val_errs;
	int				timeouts;
	logic [APP_ADDR_WIDTH-1:0]	aw_words[$];	// Word addresses waiting for their W beat
	logic [AXI_DATA_WIDTH-1:0]	w_beats[$];

	traffic_top #(
		.APP_DATA_WIDTH	(APP_DATA_WIDTH),
		.APP_ADDR_WIDTH	(APP_ADDR_WIDTH),
		.AXI_ID_WIDTH	(AXI_ID_WIDTH),
		.NUM_WORDS	(NUM_WORDS)
	) u_traffic_top (
		.i_clk(clk), .i_rst(rst), .i_calib_done(calib_done),
		.i_start(start), .i_start_addr(start_addr),
		.o_busy(busy), .o_done(done), .o_err_cnt(err_cnt),
		.o_first_err_valid(first_err_valid), .o_first_err_addr(first_err_addr),
		.o_m_axi_awid(m_axi_awid), .o_m_axi_awaddr(m_axi_awaddr),
		.o_m_axi_awlen(m_axi_awlen), .o_m_axi_awsize(m_axi_awsize),
		.o_m_axi_awburst(m_axi_awburst), .o_m_axi_awvalid(m_axi_awvalid),
		.i_m_axi_awready(m_axi_awready),
		.o_m_axi_wdata(m_axi_wdata), .o_m_axi_wstrb(m_axi_wstrb),
		.o_m_axi_wlast(m_axi_wlast), .o_m_axi_wvalid(m_axi_wvalid),
		.i_m_axi_wready(m_axi_wready),
		.i_m_axi_bresp(m_axi_bresp), .i_m_axi_bvalid(m_axi_bvalid),
		.o_m_axi_bready(m_axi_bready),
		.o_m_axi_arid(m_axi_arid), .o_m_axi_araddr(m_axi_araddr),
		.o_m_axi_arlen(m_axi_arlen), .o_m_axi_arsize(m_axi_arsize),
		.o_m_axi_arburst(m_axi_arburst), .o_m_axi_arvalid(m_axi_arvalid),
		.i_m_axi_arready(m_axi_arready),
		.i_m_axi_rdata(m_axi_rdata), .i_m_axi_rresp(m_axi_rresp),
		.i_m_axi_rvalid(m_axi_rvalid), .o_m_axi_rready(m_axi_rready)
	);

	tb_axi_mem #(
		.ADDR_WIDTH	(AXI_ADDR_WIDTH),
		.DATA_WIDTH	(AXI_DATA_WIDTH),
		.SEED		(32'h31654fcd)
	) u_axi_mem (
		.i_clk(clk), .i_rst(rst),
		.i_awaddr(m_axi_awaddr), .i_awvalid(m_axi_awvalid), .o_awready(m_axi_awready),
		.i_wdata(m_axi_wdata), .i_wvalid(m_axi_wvalid), .o_wready(m_axi_wready),
		.o_bresp(m_axi_bresp), .o_bvalid(m_axi_bvalid), .i_bready(m_axi_bready),
		.i_araddr(m_axi_araddr), .i_arvalid(m_axi_arvalid), .o_arready(m_axi_arready),
		.o_rdata(m_axi_rdata), .o_rresp(m_axi_rresp), .o_rvalid(m_axi_rvalid),
		.i_rready(m_axi_rready),
		.i_corrupt_en(corrupt_en), .i_corrupt_addr(corrupt_addr),
		.i_bad_resp_en(bad_resp_en), .i_bad_resp_addr(bad_resp_addr)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;	// 4 ns period
	end

	// Upper half is the inverted address, lower half the address, both zero-extended
	function automatic logic [APP_DATA_WIDTH-1:0] exp_word(input logic [APP_ADDR_WIDTH-1:0] a);
		logic [HALF-1:0] lo;
		logic [HALF-1:0] hi;
		lo = '0;
		hi = '0;
		for (int b = 0; b < APP_ADDR_WIDTH && b < HALF; b++)
		begin
			lo[b] = a[b];
			hi[b] = !a[b];
		end
		return {hi, lo};
	endfunction

	// Halves doubled, then the doubled word repeated
	function automatic logic [AXI_DATA_WIDTH-1:0] exp_beat(input logic [APP_ADDR_WIDTH-1:0] a);
		logic [APP_DATA_WIDTH-1:0]	w;
		logic [2*APP_DATA_WIDTH-1:0]	dbl;
		w = exp_word(a);
		dbl = {w[APP_DATA_WIDTH-1:HALF], w[APP_DATA_WIDTH-1:HALF], w[HALF-1:0], w[HALF-1:0]};
		return {(LANE_FACTOR / 2){dbl}};
	endfunction

	function automatic logic [AXI_ADDR_WIDTH-1:0] byte_addr(input logic [APP_ADDR_WIDTH-1:0] w);
		return AXI_ADDR_WIDTH'(w) * AXI_ADDR_WIDTH'(AXI_BYTES);
	endfunction

	task automatic check_beat(input string name, input logic [AXI_DATA_WIDTH-1:0] exp,
		input logic [AXI_DATA_WIDTH-1:0] act);
		if (act !== exp)
		begin
			$display("FAILED %s: expected %h, actual %h", name, exp, act);
			val_errs++;
		end
	endtask

	task automatic check_count(input string name, input logic [ERR_CNT_WIDTH-1:0] exp,
		input logic [ERR_CNT_WIDTH-1:0] act);
		if (act !== exp)
		begin
			$display("FAILED %s: expected %0d, actual %0d", name, exp, act);
			val_errs++;
		end
	endtask

	task automatic check_addr(input string name, input logic [APP_ADDR_WIDTH-1:0] exp,
		input logic [APP_ADDR_WIDTH-1:0] act);
		if (act !== exp)
		begin
			$display("FAILED %s: expected %h, actual %h", name, exp, act);
			val_errs++;
		end
	endtask

	task automatic check_axi_addr(input string name, input logic [AXI_ADDR_WIDTH-1:0] exp,
		input logic [AXI_ADDR_WIDTH-1:0] act);
		if (act !== exp)
		begin
			$display("FAILED %s: expected %h, actual %h", name, exp, act);
			val_errs++;
		end
	endtask

	// ID, len, size and burst fields, zero-extended
	task automatic check_field(input string name, input logic [7:0] exp,
		input logic [7:0] act);
		if (act !== exp)
		begin
			$display("FAILED %s: expected %h, actual %h", name, exp, act);
			val_errs++;
		end
	endtask

	task automatic check_strb(input string name, input logic [AXI_BYTES-1:0] exp,
		input logic [AXI_BYTES-1:0] act);
		if (act !== exp)
		begin
			$display("FAILED %s: expected %h, actual %h", name, exp, act);
			val_errs++;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			$display("FAILED %s: expected %b, actual %b", name, exp, act);
			val_errs++;
		end
	endtask

	// Handshakes sampled at the edge with addresses expected in ascending order
	always @(posedge clk)
	begin : bus_monitor
		logic [APP_ADDR_WIDTH-1:0]	w_word;
		logic [AXI_DATA_WIDTH-1:0]	w_beat;
		if (!rst)
		begin
			if (m_axi_awvalid && m_axi_awready)
			begin
				check_axi_addr("aw address", byte_addr(run_base + APP_ADDR_WIDTH'(aw_idx)),
					m_axi_awaddr);
				check_field("awid", 8'd0, 8'(m_axi_awid));
				check_field("awlen", 8'd0, m_axi_awlen);	// Single beat
				check_field("awsize", 8'($clog2(AXI_BYTES)), 8'(m_axi_awsize));
				check_field("awburst", 8'(AXI_BURST_INCR), 8'(m_axi_awburst));
				aw_words.push_back(APP_ADDR_WIDTH'(m_axi_awaddr / AXI_BYTES));
				aw_idx++;
			end
			if (m_axi_wvalid && m_axi_wready)
			begin
				w_beats.push_back(m_axi_wdata);
				check_strb("wstrb", '1, m_axi_wstrb);	// All bytes written
				check_bit("wlast", 1'b1, m_axi_wlast);
			end
			if (aw_words.size() > 0 && w_beats.size() > 0)
			begin
				w_word = aw_words.pop_front();
				w_beat = w_beats.pop_front();
				check_beat("w beat", exp_beat(w_word), w_beat);
			end
			if (m_axi_arvalid && m_axi_arready)
			begin
				check_axi_addr("ar address", byte_addr(run_base + APP_ADDR_WIDTH'(ar_idx)),
					m_axi_araddr);
				check_field("arid", 8'd0, 8'(m_axi_arid));
				check_field("arlen", 8'd0, m_axi_arlen);
				check_field("arsize", 8'($clog2(AXI_BYTES)), 8'(m_axi_arsize));
				check_field("arburst", 8'(AXI_BURST_INCR), 8'(m_axi_arburst));
				ar_idx++;
			end
		end
	end

	// One start pulse, then wait for done
	task automatic run_block(input string name, input logic [APP_ADDR_WIDTH-1:0] base,
		output bit ok);
		int cycles;
		run_base = base;
		aw_idx = 0;
		ar_idx = 0;
		@(posedge clk);
		start_addr <= base;
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		@(posedge clk);
		check_bit({name, " busy after start"}, 1'b1, busy);
		cycles = 0;
		while (!done && cycles < TIMEOUT)
		begin
			@(posedge clk);
			cycles++;
		end
		ok = done;
		if (!ok)
		begin
			$display("ERROR: %s never raised o_done within %0d cycles", name, TIMEOUT);
			timeouts++;
		end
		else
		begin
			check_count({name, " aw count"}, ERR_CNT_WIDTH'(NUM_WORDS), ERR_CNT_WIDTH'(aw_idx));
			check_count({name, " ar count"}, ERR_CNT_WIDTH'(NUM_WORDS), ERR_CNT_WIDTH'(ar_idx));
		end
	endtask

	initial
	begin
		bit ok;
		rst = 1'b1;
		calib_done = 1'b0;
		start = 1'b0;
		start_addr = '0;
		corrupt_en = 1'b0;
		corrupt_addr = '0;
		bad_resp_en = 1'b0;
		bad_resp_addr = '0;
		run_base = '0;
		aw_idx = 0;
		ar_idx = 0;
		val_errs = 0;
		timeouts = 0;
		ok = 1'b0;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		repeat (2) @(posedge clk);
		check_bit("awvalid after reset", 1'b0, m_axi_awvalid);
		check_bit("wvalid after reset", 1'b0, m_axi_wvalid);
		check_bit("arvalid after reset", 1'b0, m_axi_arvalid);
		check_bit("bready after reset", 1'b0, m_axi_bready);
		check_bit("rready after reset", 1'b0, m_axi_rready);
		check_bit("busy after reset", 1'b0, busy);
		check_bit("done after reset", 1'b0, done);
		// Start before calibration must be ignored
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		repeat (2) @(posedge clk);
		check_bit("busy without calibration", 1'b0, busy);
		calib_done <= 1'b1;
		run_block("clean run", BASE_A, ok);
		if (ok)
		begin
			check_count("clean run err_cnt", '0, err_cnt);
			check_bit("clean run first_err_valid", 1'b0, first_err_valid);
			@(posedge clk);
			corrupt_en <= 1'b1;	// One copy flipped when stored
			corrupt_addr <= byte_addr(CORRUPT_WORD);
			run_block("corrupt lane run", BASE_A, ok);
		end
		if (ok)
		begin
			check_count("corrupt lane err_cnt", ERR_CNT_WIDTH'(1), err_cnt);
			check_bit("corrupt lane first_err_valid", 1'b1, first_err_valid);
			check_addr("corrupt lane first_err_addr", CORRUPT_WORD, first_err_addr);
			@(posedge clk);
			corrupt_en <= 1'b0;
			bad_resp_en <= 1'b1;	// Data intact but rresp bad
			bad_resp_addr <= byte_addr(BAD_RESP_WORD);
			run_block("bad rresp run", BASE_B, ok);
		end
		if (ok)
		begin
			check_count("bad rresp err_cnt", ERR_CNT_WIDTH'(1), err_cnt);
			check_bit("bad rresp first_err_valid", 1'b1, first_err_valid);
			check_addr("bad rresp first_err_addr", BAD_RESP_WORD, first_err_addr);
		end
		$display("Error count: %0d value mismatches, %0d timeouts", val_errs, timeouts);
		if (val_errs == 0 && timeouts == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
tg_pkg.sv
axi_pkg.sv
app_if.sv
tg_sequencer.sv
app_axi_bridge.sv
lane_fold.sv
traffic_top.sv
tb_axi_mem.sv
tb_traffic_top.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, then scan the log
rm -rf obj_dir sim.log
verilator --binary -j 0 -Wno-fatal --top-module tb_traffic_top -f verilog.f \
	&& ./obj_dir/Vtb_traffic_top > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }
cat sim.log
grep -q "=== FAIL ===" sim.log && { echo "Simulation failed"; exit 1; } \
	|| echo "Simulation finished without failures"
